// ==== common/gb_bus_pkg.sv ====
package gb_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus request and port structs
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        need_vram;
		logic        need_oam;
	} ppu_req_t;

	// Cartridge slot and work RAM
	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
		logic        drive_data; // Data pins driven by us
	} ext_bus_t;

	typedef struct packed {
		logic [15:0] adr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} mem_port_t;

	typedef enum logic [2:0] {
		REG_ROM,
		REG_VRAM,
		REG_XRAM,
		REG_WRAM,
		REG_OAM,
		REG_IO,
		REG_HRAM,
		REG_NONE
	} region_t;

	//////////////////////////////////////////////////////////////////////
	// Memory map
	//////////////////////////////////////////////////////////////////////

	localparam logic [15:0] VRAM_BASE = 16'h8000;
	localparam logic [15:0] XRAM_BASE = 16'ha000;
	localparam logic [15:0] WRAM_BASE = 16'hc000;
	localparam logic [15:0] ECHO_BASE = 16'he000; // Mirror of C000-DDFF
	localparam logic [15:0] OAM_BASE  = 16'hfe00;
	localparam logic [15:0] OAM_END   = 16'hfea0; // First byte past OAM
	localparam logic [15:0] IO_BASE   = 16'hff00;
	localparam logic [15:0] HRAM_BASE = 16'hff80;
	localparam logic [15:0] IE_ADR    = 16'hffff;

	localparam logic [15:0] DMA_REG_ADR = 16'hff46;
	localparam int          DMA_LEN     = 160;  // Bytes per OAM copy
	localparam logic [7:0]  OPEN_BUS    = 8'hff;

endpackage

// ==== bus/addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode import gb_bus_pkg::*; (
	input  logic [15:0] adr,
	output region_t     region
);

	//////////////////////////////////////////////////////////////////////
	// Console memory map
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (adr < VRAM_BASE)
			region = REG_ROM;   // Cartridge ROM, both banks
		else if (adr < XRAM_BASE)
			region = REG_VRAM;
		else if (adr < WRAM_BASE)
			region = REG_XRAM;  // Cartridge RAM
		else if (adr < ECHO_BASE)
			region = REG_WRAM;
		else if (adr < OAM_BASE)
			region = REG_WRAM;  // Echo area, same chip
		else if (adr < OAM_END)
			region = REG_OAM;
		else if (adr < IO_BASE)
			region = REG_NONE;  // FEA0-FEFF gap
		else if (adr < HRAM_BASE)
			region = REG_IO;
		else if (adr == IE_ADR)
			region = REG_NONE;  // No interrupt controller here
		else
			region = REG_HRAM;
	end

endmodule

// ==== reset/reset_seq.sv ====
`timescale 1ns/1ps

module reset_seq #(
	parameter int RST_TICK_W = 4
) (
	input  logic gbclk,
	input  logic rst,
	input  logic power_on,
	input  logic cart_n_rst_in,
	output logic reset_gb,
	output logic cart_n_rst_out
);

	typedef enum logic [1:0] {
		PH_ASSERT  = 2'd0,
		PH_RELEASE = 2'd1,
		PH_DONE    = 2'd2
	} phase_t;

	phase_t phase, phase_nxt;
	logic [RST_TICK_W-1:0] por_ticks;
	logic por_done;
	logic [RST_TICK_W-1:0] ticks, ticks_nxt;
	logic power_q;
	logic restart;

	// Power toggle, or the cartridge pulling reset once we are running
	assign restart = (power_on != power_q) || (phase == PH_DONE && !cart_n_rst_in);

	always_comb begin
		phase_nxt = phase;
		ticks_nxt = ticks;
		if (restart) begin
			phase_nxt = PH_ASSERT;
			ticks_nxt = '0;
		end else if (por_done) begin
			case (phase)
			PH_ASSERT: begin
				if (&ticks) begin
					phase_nxt = PH_RELEASE;
					ticks_nxt = '0;
				end else
					ticks_nxt = ticks + 1'b1;
			end
			PH_RELEASE: begin
				if (!cart_n_rst_in)
					ticks_nxt = '0; // Cartridge still holding its line
				else if (&ticks)
					phase_nxt = PH_DONE;
				else
					ticks_nxt = ticks + 1'b1;
			end
			default: ;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		power_q <= power_on;
		if (rst) begin
			por_ticks <= '0;
			por_done  <= 1'b0;
			phase     <= PH_ASSERT;
			ticks     <= '0;
		end else begin
			if (!por_done) begin
				por_ticks <= por_ticks + 1'b1;
				if (&por_ticks)
					por_done <= 1'b1;
			end
			phase <= phase_nxt;
			ticks <= ticks_nxt;
		end
	end

	assign reset_gb       = (phase != PH_DONE) || restart || !power_on;
	assign cart_n_rst_out = power_on && !(por_done && phase == PH_ASSERT);

	phase_legal: assert property (@(posedge gbclk) disable iff (rst)
		phase inside {PH_ASSERT, PH_RELEASE, PH_DONE})
		else $error("reset_seq: illegal phase %0d", phase);

endmodule

// ==== bus/oam_dma.sv ====
`timescale 1ns/1ps

module oam_dma import gb_bus_pkg::*; (
	input  logic       gbclk,
	input  logic       rst,
	input  logic       reg_wr,
	input  logic [7:0] reg_data,
	output mem_port_t  dma_rd,
	input  logic [7:0] dma_rdata,
	output mem_port_t  dma_oam_wr,
	output logic       dma_active
);

	logic [7:0] page;   // Source page, high address byte
	logic [7:0] idx;    // Next byte to read
	logic [7:0] wr_idx; // Byte whose read data arrives now
	logic rd_act;
	logic wr_act;

	always_ff @(posedge gbclk) begin
		if (rst) begin
			rd_act <= 1'b0;
			wr_act <= 1'b0;
			idx    <= '0;
		end else begin
			wr_act <= rd_act;
			if (reg_wr) begin
				idx    <= '0;
				rd_act <= 1'b1;
			end else if (rd_act) begin
				idx <= idx + 1'b1;
				if (idx == DMA_LEN - 1)
					rd_act <= 1'b0;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (reg_wr)
			page <= reg_data;
		wr_idx <= idx;
	end

	always_comb begin
		dma_rd.adr   = {page, idx};
		dma_rd.rd    = rd_act;
		dma_rd.wr    = 1'b0;
		dma_rd.wdata = '0;

		// Read data of the previous cycle goes straight into OAM
		dma_oam_wr.adr   = OAM_BASE + {8'h00, wr_idx};
		dma_oam_wr.rd    = 1'b0;
		dma_oam_wr.wr    = wr_act;
		dma_oam_wr.wdata = dma_rdata;
	end

	assign dma_active = rd_act || wr_act;

	idx_in_range: assert property (@(posedge gbclk) disable iff (rst)
		rd_act |-> idx < DMA_LEN)
		else $error("oam_dma: index %0d past end of OAM", idx);

endmodule

// ==== bus/bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric import gb_bus_pkg::*; (
	input  logic       gbclk,
	input  logic       rst,
	input  cpu_bus_t   cpu,
	output logic [7:0] cpu_rdata,
	input  mem_port_t  dma_rd,
	input  logic       dma_active,
	output logic [7:0] dma_rdata,
	output logic       dma_reg_wr,
	output ext_bus_t   ext,
	input  logic [7:0] ext_rdata,
	output mem_port_t  vram_cpu,
	output mem_port_t  oam_cpu,
	output mem_port_t  vram_dma,
	input  logic [7:0] vram_rdata,
	input  logic [7:0] oam_rdata
);

	region_t cpu_reg, dma_reg;
	region_t cpu_reg_q, dma_reg_q;
	logic cpu_ext, dma_own, dma_vram;
	logic dma_own_q, dma_vram_q;
	logic wr_q;
	logic [7:0] hram [0:126];
	logic [7:0] hram_q;

	addr_decode cpu_dec (.adr(cpu.adr), .region(cpu_reg));
	addr_decode dma_dec (.adr(dma_rd.adr), .region(dma_reg));

	function automatic logic [15:0] fold_echo(logic [15:0] adr, region_t reg_sel);
		if (reg_sel == REG_WRAM && adr >= ECHO_BASE)
			return adr - (ECHO_BASE - WRAM_BASE);
		return adr;
	endfunction

	assign cpu_ext    = cpu_reg inside {REG_ROM, REG_XRAM, REG_WRAM};
	assign dma_own    = dma_active && (dma_reg inside {REG_ROM, REG_XRAM, REG_WRAM});
	assign dma_vram   = dma_active && dma_rd.rd && dma_reg == REG_VRAM;
	assign dma_reg_wr = cpu.wr && cpu.adr == DMA_REG_ADR;

	//////////////////////////////////////////////////////////////////////
	// External bus owner
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ext.wdata = cpu.wdata;
		if (dma_own) begin
			ext.adr = fold_echo(dma_rd.adr, dma_reg);
			ext.rd  = dma_rd.rd;
			ext.wr  = 1'b0;
		end else begin
			ext.adr = fold_echo(cpu.adr, cpu_reg);
			ext.rd  = cpu.rd && cpu_ext;
			ext.wr  = cpu.wr && cpu_ext;
		end
		ext.drive_data = ext.wr || wr_q; // Hold data one cycle past the strobe
	end

	always_comb begin
		vram_cpu = '{adr: cpu.adr, rd: cpu.rd && cpu_reg == REG_VRAM,
			wr: cpu.wr && cpu_reg == REG_VRAM, wdata: cpu.wdata};
		oam_cpu  = '{adr: cpu.adr, rd: cpu.rd && cpu_reg == REG_OAM,
			wr: cpu.wr && cpu_reg == REG_OAM, wdata: cpu.wdata};
		vram_dma = '{adr: dma_rd.adr, rd: dma_vram, wr: 1'b0, wdata: '0};
	end

	always_ff @(posedge gbclk) begin
		if (rst) begin
			cpu_reg_q  <= REG_NONE;
			dma_reg_q  <= REG_NONE;
			dma_own_q  <= 1'b0;
			dma_vram_q <= 1'b0;
			wr_q       <= 1'b0;
		end else begin
			cpu_reg_q  <= cpu_reg;
			dma_reg_q  <= dma_reg;
			dma_own_q  <= dma_own;
			dma_vram_q <= dma_vram;
			wr_q       <= ext.wr;
		end
	end

	// High RAM, FF80-FFFE
	always_ff @(posedge gbclk) begin
		if (cpu.wr && cpu_reg == REG_HRAM)
			hram[cpu.adr[6:0]] <= cpu.wdata;
		if (cpu.rd && cpu_reg == REG_HRAM)
			hram_q <= hram[cpu.adr[6:0]];
	end

	//////////////////////////////////////////////////////////////////////
	// Read data, one cycle after the request
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (cpu_reg_q)
		REG_ROM, REG_XRAM, REG_WRAM: cpu_rdata = dma_own_q ? OPEN_BUS : ext_rdata;
		REG_VRAM: cpu_rdata = dma_vram_q ? OPEN_BUS : vram_rdata;
		REG_OAM:  cpu_rdata = oam_rdata;
		REG_HRAM: cpu_rdata = hram_q;
		default:  cpu_rdata = OPEN_BUS; // I/O, gap and IE
		endcase

		case (dma_reg_q)
		REG_ROM, REG_XRAM, REG_WRAM: dma_rdata = ext_rdata;
		REG_VRAM: dma_rdata = vram_rdata;
		default:  dma_rdata = OPEN_BUS;
		endcase
	end

	cpu_rd_wr_excl: assert property (@(posedge gbclk) disable iff (rst)
		cpu.rd |-> !cpu.wr)
		else $error("bus_fabric: CPU read and write in one cycle");

endmodule

// ==== src/video_mem.sv ====
`timescale 1ns/1ps

module video_mem import gb_bus_pkg::*; #(
	parameter int VRAM_AW = 13
) (
	input  logic       gbclk,
	input  ppu_req_t   ppu,
	input  mem_port_t  vram_cpu,
	input  mem_port_t  oam_cpu,
	input  mem_port_t  vram_dma,
	input  mem_port_t  dma_oam_wr,
	input  logic       dma_active,
	output logic [7:0] vram_rdata,
	output logic [7:0] oam_rdata,
	output logic [7:0] ppu_rdata
);

	logic [7:0] vram [0:2**VRAM_AW-1];
	logic [7:0] oam [0:DMA_LEN-1];
	logic vram_dma_win, vram_cpu_win, oam_dma_win, oam_cpu_win;
	logic vram_re, oam_re;
	logic [VRAM_AW-1:0] vram_idx;
	logic [7:0] oam_idx;
	logic [7:0] vram_q, oam_q;
	logic vram_ppu_q, oam_lost_q, ppu_oam_q;

	// Priority PPU, then DMA, then CPU
	assign vram_dma_win = !ppu.need_vram && dma_active && vram_dma.rd;
	assign vram_cpu_win = !ppu.need_vram && !vram_dma_win;
	assign oam_dma_win  = !ppu.need_oam && dma_active;
	assign oam_cpu_win  = !ppu.need_oam && !dma_active;

	always_comb begin
		if (ppu.need_vram)
			vram_idx = ppu.adr[VRAM_AW-1:0];
		else if (vram_dma_win)
			vram_idx = vram_dma.adr[VRAM_AW-1:0];
		else
			vram_idx = vram_cpu.adr[VRAM_AW-1:0];
		vram_re = ppu.need_vram ? ppu.rd : (vram_dma_win || vram_cpu.rd);

		if (ppu.need_oam)
			oam_idx = ppu.adr[7:0];
		else if (oam_dma_win)
			oam_idx = dma_oam_wr.adr[7:0];
		else
			oam_idx = oam_cpu.adr[7:0];
		oam_re = ppu.need_oam ? ppu.rd : oam_cpu.rd;
	end

	always_ff @(posedge gbclk) begin
		if (vram_cpu_win && vram_cpu.wr)
			vram[vram_idx] <= vram_cpu.wdata;
		if (vram_re)
			vram_q <= vram[vram_idx];
		vram_ppu_q <= ppu.need_vram;
	end

	always_ff @(posedge gbclk) begin
		if (oam_dma_win && dma_oam_wr.wr)
			oam[oam_idx] <= dma_oam_wr.wdata;
		else if (oam_cpu_win && oam_cpu.wr)
			oam[oam_idx] <= oam_cpu.wdata;
		if (oam_re)
			oam_q <= oam[oam_idx];
		oam_lost_q <= !oam_cpu_win;
		ppu_oam_q  <= ppu.need_oam && !ppu.need_vram;
	end

	assign vram_rdata = vram_ppu_q ? OPEN_BUS : vram_q;
	assign oam_rdata  = oam_lost_q ? OPEN_BUS : oam_q;
	assign ppu_rdata  = vram_ppu_q ? vram_q : (ppu_oam_q ? oam_q : OPEN_BUS);

	// A DMA write strobe outside the copy window would collide with the CPU
	oam_one_writer: assert property (@(posedge gbclk)
		dma_oam_wr.wr |-> !(oam_cpu_win && oam_cpu.wr))
		else $error("video_mem: DMA and CPU both write OAM");

endmodule

// ==== src/gb_bus_top.sv ====
`timescale 1ns/1ps

module gb_bus_top import gb_bus_pkg::*; #(
	parameter int RST_TICK_W = 4,
	parameter int VRAM_AW    = 13
) (
	input  logic       gbclk,
	input  logic       rst,
	input  logic       power_on,
	input  logic       cart_n_rst_in,
	output logic       cart_n_rst_out,
	output logic       reset_gb,
	input  cpu_bus_t   cpu,
	output logic [7:0] cpu_rdata,
	input  ppu_req_t   ppu,
	output logic [7:0] ppu_rdata,
	output ext_bus_t   ext,
	input  logic [7:0] ext_rdata,
	output logic       dma_active
);

	mem_port_t dma_rd, dma_oam_wr;
	mem_port_t vram_cpu, oam_cpu, vram_dma;
	logic [7:0] dma_rdata;
	logic [7:0] vram_rdata, oam_rdata;
	logic dma_reg_wr;

	reset_seq #(.RST_TICK_W(RST_TICK_W)) reset_seq_inst (
		.gbclk          (gbclk),
		.rst            (rst),
		.power_on       (power_on),
		.cart_n_rst_in  (cart_n_rst_in),
		.reset_gb       (reset_gb),
		.cart_n_rst_out (cart_n_rst_out)
	);

	bus_fabric bus_fabric_inst (
		.gbclk      (gbclk),
		.rst        (reset_gb),
		.cpu        (cpu),
		.cpu_rdata  (cpu_rdata),
		.dma_rd     (dma_rd),
		.dma_active (dma_active),
		.dma_rdata  (dma_rdata),
		.dma_reg_wr (dma_reg_wr),
		.ext        (ext),
		.ext_rdata  (ext_rdata),
		.vram_cpu   (vram_cpu),
		.oam_cpu    (oam_cpu),
		.vram_dma   (vram_dma),
		.vram_rdata (vram_rdata),
		.oam_rdata  (oam_rdata)
	);

	oam_dma oam_dma_inst (
		.gbclk      (gbclk),
		.rst        (reset_gb),
		.reg_wr     (dma_reg_wr),
		.reg_data   (cpu.wdata),
		.dma_rd     (dma_rd),
		.dma_rdata  (dma_rdata),
		.dma_oam_wr (dma_oam_wr),
		.dma_active (dma_active)
	);

	video_mem #(.VRAM_AW(VRAM_AW)) video_mem_inst (
		.gbclk      (gbclk),
		.ppu        (ppu),
		.vram_cpu   (vram_cpu),
		.oam_cpu    (oam_cpu),
		.vram_dma   (vram_dma),
		.dma_oam_wr (dma_oam_wr),
		.dma_active (dma_active),
		.vram_rdata (vram_rdata),
		.oam_rdata  (oam_rdata),
		.ppu_rdata  (ppu_rdata)
	);

endmodule

// ==== sim/gb_bus_tb.sv ====
`timescale 1ns/1ps

module gb_bus_tb import gb_bus_pkg::*; ();

	localparam int RST_TICK_W = 4;
	localparam int VRAM_AW    = 13;
	localparam int TICKS      = 2**RST_TICK_W;
	localparam int HOLD       = 20; // Cartridge keeps its reset low this long
	localparam int VRAM_N     = 32;
	localparam int RUN_CYCLES = 6*TICKS + HOLD + 2*127 + 2*VRAM_N + 2*DMA_LEN + 80;
	localparam int MAX_CYCLES = 2*RUN_CYCLES;

	logic gbclk, rst, power_on, cart_n_rst_in;
	logic cart_n_rst_out, reset_gb, dma_active;
	cpu_bus_t cpu;
	ppu_req_t ppu;
	ext_bus_t ext;
	logic [7:0] cpu_rdata, ppu_rdata, ext_rdata;

	integer seed = 32'hb7d12d18;
	int cycle_cnt;
	int err_total, err_start, pass_cnt, fail_cnt;
	string cur_test;
	logic [7:0] hram_exp [0:126];
	logic [7:0] vram_exp [0:VRAM_N-1];

	gb_bus_top #(.RST_TICK_W(RST_TICK_W), .VRAM_AW(VRAM_AW)) gb_bus_top_inst (
		.gbclk          (gbclk),
		.rst            (rst),
		.power_on       (power_on),
		.cart_n_rst_in  (cart_n_rst_in),
		.cart_n_rst_out (cart_n_rst_out),
		.reset_gb       (reset_gb),
		.cpu            (cpu),
		.cpu_rdata      (cpu_rdata),
		.ppu            (ppu),
		.ppu_rdata      (ppu_rdata),
		.ext            (ext),
		.ext_rdata      (ext_rdata),
		.dma_active     (dma_active)
	);

	initial begin
		gbclk = 1'b0;
		forever #5 gbclk = ~gbclk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge gbclk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// External memory model with data that follows the address
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] ext_data(input logic [15:0] adr);
		return adr[15:8] ^ {adr[6:0], adr[7]} ^ 8'h96;
	endfunction

	always @(posedge gbclk)
		if (ext.rd)
			ext_rdata <= ext_data(ext.adr);

	drive_hold: assert property (@(posedge gbclk) disable iff (reset_gb)
		ext.wr |=> ext.drive_data)
		else begin
			$display("ERROR: drive_data dropped in the cycle after an external write");
			err_total++;
		end

	drive_release: assert property (@(posedge gbclk) disable iff (reset_gb)
		!ext.wr && !$past(ext.wr) |-> !ext.drive_data)
		else begin
			$display("ERROR: drive_data high with no recent external write");
			err_total++;
		end

	dma_start: assert property (@(posedge gbclk) disable iff (reset_gb)
		$rose(dma_active) |-> $past(cpu.wr && cpu.adr == DMA_REG_ADR))
		else begin
			$display("ERROR: dma_active rose without a write to the DMA register");
			err_total++;
		end

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp)
		else begin
			$display("ERROR %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			err_total++;
		end
	endtask

	task automatic check_range(input string what, input int lo, input int hi, input int act);
		assert (act >= lo && act <= hi)
		else begin
			$display("ERROR %s: %s expected %0d..%0d actual %0d", cur_test, what, lo, hi, act);
			err_total++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_start = err_total;
	endtask

	task automatic end_test();
		if (err_total == err_start) begin
			pass_cnt++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", cur_test, err_total - err_start);
		end
	endtask

	// All bus tasks start and end on a falling edge
	task automatic cpu_write(input logic [15:0] adr, input logic [7:0] data);
		cpu.adr = adr;
		cpu.wdata = data;
		cpu.wr = 1'b1;
		@(negedge gbclk);
		cpu.wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] adr, output logic [7:0] data);
		cpu.adr = adr;
		cpu.rd = 1'b1;
		@(negedge gbclk);
		data = cpu_rdata;
		cpu.rd = 1'b0;
	endtask

	task automatic wait_release(input int limit, output int cycles, output int low_cycles);
		cycles = 0;
		low_cycles = 0;
		while (reset_gb !== 1'b0 && cycles < limit) begin
			@(negedge gbclk);
			cycles++;
			if (cart_n_rst_out === 1'b0)
				low_cycles++;
		end
		if (reset_gb !== 1'b0) begin
			$display("ERROR %s: reset_gb never fell within %0d cycles", cur_test, limit);
			err_total++;
		end
	endtask

	task automatic ext_read_check(input logic [15:0] adr, input logic [15:0] exp_adr);
		cpu.adr = adr;
		cpu.rd = 1'b1;
		#1;
		check_value("ext rd", 1, ext.rd);
		check_value("ext adr", exp_adr, ext.adr);
		@(negedge gbclk);
		check_value("ext read data", ext_data(exp_adr), cpu_rdata);
		cpu.rd = 1'b0;
	endtask

	task automatic open_bus_check(input logic [15:0] adr);
		cpu.adr = adr;
		cpu.rd = 1'b1;
		#1 check_value("ext rd on unmapped", 0, ext.rd);
		@(negedge gbclk);
		check_value("unmapped read", OPEN_BUS, cpu_rdata);
		cpu.rd = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		int low_cycles;
		int n;
		logic [7:0] data;
		logic [15:0] vadr;

		rst = 1'b1;
		power_on = 1'b1;
		cart_n_rst_in = 1'b1;
		cpu = '0;
		ppu = '0;
		ext_rdata = 8'h00;
		err_total = 0;
		pass_cnt = 0;
		fail_cnt = 0;

		start_test("reset_sequence");
		repeat (4) @(negedge gbclk);
		rst = 1'b0;
		wait_release(4*TICKS, cycles, low_cycles);
		check_range("reset_gb fall", 3*TICKS, 3*TICKS + 2, cycles);
		check_value("cart reset low cycles", TICKS, low_cycles);
		power_on = 1'b0;
		#1 check_value("reset_gb on power drop", 1, reset_gb);
		@(negedge gbclk);
		power_on = 1'b1;
		wait_release(4*TICKS, cycles, low_cycles);
		check_range("release after power cycle", 2*TICKS, 2*TICKS + 2, cycles);
		end_test();

		start_test("cart_hold");
		cart_n_rst_in = 1'b0;
		#1 check_value("reset_gb on cart reset", 1, reset_gb);
		@(negedge gbclk);
		cart_n_rst_in = 1'b1;
		n = 0;
		while (cart_n_rst_out !== 1'b1 && n < 4*TICKS) begin
			@(negedge gbclk);
			n++;
		end
		check_value("assert phase cycles", TICKS, n);
		cart_n_rst_in = 1'b0; // Now in RELEASE
		repeat (HOLD) begin
			@(negedge gbclk);
			check_value("reset_gb during hold", 1, reset_gb);
		end
		cart_n_rst_in = 1'b1;
		wait_release(4*TICKS, cycles, low_cycles);
		check_range("release after hold", TICKS, TICKS + 2, cycles);
		end_test();

		start_test("hram_vram");
		for (int i = 0; i < 127; i++) begin
			hram_exp[i] = 8'($random(seed));
			cpu_write(HRAM_BASE + 16'(i), hram_exp[i]);
		end
		for (int i = 0; i < 127; i++) begin
			cpu_read(HRAM_BASE + 16'(i), data);
			check_value("hram read", hram_exp[i], data);
		end
		for (int i = 0; i < VRAM_N; i++) begin
			vram_exp[i] = 8'($random(seed));
			cpu_write(VRAM_BASE + 16'(i*257), vram_exp[i]);
		end
		for (int i = 0; i < VRAM_N; i++) begin
			cpu_read(VRAM_BASE + 16'(i*257), data);
			check_value("vram read", vram_exp[i], data);
		end
		for (int i = 0; i < 4; i++) begin
			vadr = VRAM_BASE + 16'(i*257);
			ppu = '{adr: vadr, rd: 1'b1, need_vram: 1'b1, need_oam: 1'b0};
			cpu_read(VRAM_BASE + 16'((i + 4)*257), data); // Other byte than the PPU's
			check_value("cpu vram read under ppu", OPEN_BUS, data);
			check_value("ppu vram read", vram_exp[i], ppu_rdata);
		end
		ppu = '0;
		end_test();

		start_test("ext_steering");
		ext_read_check(16'h0123, 16'h0123);
		ext_read_check(16'h4567, 16'h4567);
		ext_read_check(16'ha5c3, 16'ha5c3);
		ext_read_check(16'hc0de, 16'hc0de);
		ext_read_check(16'he0de, 16'hc0de); // Echo lands on WRAM
		open_bus_check(16'hff00);
		open_bus_check(16'hff7f);
		open_bus_check(16'hfea0);
		open_bus_check(IE_ADR);
		cpu.adr = 16'hc123;
		cpu.wdata = 8'h3c;
		cpu.wr = 1'b1;
		#1;
		check_value("drive_data in write", 1, ext.drive_data);
		check_value("ext wr", 1, ext.wr);
		check_value("ext write adr", 16'hc123, ext.adr);
		check_value("ext wdata", 8'h3c, ext.wdata);
		@(negedge gbclk);
		cpu.wr = 1'b0;
		#1;
		check_value("drive_data after write", 1, ext.drive_data);
		check_value("ext wr after write", 0, ext.wr);
		@(negedge gbclk);
		#1 check_value("drive_data released", 0, ext.drive_data);
		end_test();

		start_test("oam_dma");
		cpu_write(DMA_REG_ADR, 8'hc1);
		for (int k = 0; k < DMA_LEN; k++) begin
			cpu.adr = (k % 2 == 0) ? OAM_BASE + 16'(k) : 16'hd000 + 16'(k);
			cpu.rd = 1'b1;
			#1;
			check_value("dma active", 1, dma_active);
			check_value("dma ext rd", 1, ext.rd);
			check_value("dma ext adr", 16'hc100 + 16'(k), ext.adr);
			@(negedge gbclk);
			check_value("cpu read during dma", OPEN_BUS, cpu_rdata);
		end
		cpu.rd = 1'b0;
		#1;
		check_value("dma active on last write", 1, dma_active);
		check_value("ext rd after copy", 0, ext.rd);
		@(negedge gbclk);
		#1 check_value("dma idle", 0, dma_active);
		for (int k = 0; k < DMA_LEN; k++) begin
			cpu_read(OAM_BASE + 16'(k), data);
			check_value("oam byte", ext_data(16'hc100 + 16'(k)), data);
		end
		end_test();

		$display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_total);
		if (fail_cnt == 0 && err_total == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
common/gb_bus_pkg.sv
bus/addr_decode.sv
reset/reset_seq.sv
bus/oam_dma.sv
bus/bus_fabric.sv
src/video_mem.sv
src/gb_bus_top.sv
sim/gb_bus_tb.sv

// ==== Bender.yml ====
package:
  name: gb_bus

sources:
  - common/gb_bus_pkg.sv
  - bus/addr_decode.sv
  - reset/reset_seq.sv
  - bus/oam_dma.sv
  - bus/bus_fabric.sv
  - src/video_mem.sv
  - src/gb_bus_top.sv
  - target: simulation
    files:
      - sim/gb_bus_tb.sv
